//--- rtl/fetch_params.svh
// cache and address geometry for the fetch subsystem
// TAG_BITS + ICACHE_LINE_BITS + OFFSET_BITS must equal ADDR_BITS

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////
// address geometry
////////////////////

// byte address width
`define ADDR_BITS 16
// 8 byte line, two 32-bit instructions
`define OFFSET_BITS 3

////////////////////
// cache geometry
////////////////////

// direct mapped, 16 lines
`define ICACHE_LINE_BITS 4
`define ICACHE_LINES 16
// address bits above the index
`define TAG_BITS 9
// lines visible to the fetch window, pc line plus the next one
`define PREFETCH_DISTANCE 2

// first fetch address after reset
`define RESET_PC 16'h0000

`endif

//--- rtl/fetch_pkg.sv
// shared types for the fetch path
// word 0 of a line sits at the lower byte address

`include "fetch_params.svh"

package fetch_pkg;

    ////////////////////
    // cache line
    ////////////////////

    // two instruction words, index by offset bit 2
    typedef logic [1:0][31:0] line_t;

    ////////////////////
    // fetch address
    ////////////////////

    // one 16-bit byte address with two views
    // raw is used by the fill path and on the bus
    // f is used by the cache for lookup
    typedef union packed {
        logic [`ADDR_BITS-1:0] raw;
        struct packed {
            // bits above the index
            logic [`TAG_BITS-1:0]         tag;
            // selects one of the cache lines
            logic [`ICACHE_LINE_BITS-1:0] index;
            // byte within the line
            logic [`OFFSET_BITS-1:0]      offset;
        } f;
    } fetch_addr_u;

endpackage

//--- rtl/line_fill_master.sv
// one fill outstanding at a time, memory is assumed to answer OKAY
// fill_ack is registered, so it comes one cycle after fill_req

`timescale 1ns/1ps
`include "fetch_params.svh"

module line_fill_master
    import fetch_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    // fill request from the fetch window
    input  logic                  fill_req,
    input  fetch_addr_u           fill_addr,
    output logic                  fill_ack,
    // pending mark into the cache
    output logic                  alloc_en,
    output fetch_addr_u           alloc_addr,
    // AXI4-Lite read address channel
    output logic                  arvalid,
    input  logic                  arready,
    output logic [`ADDR_BITS-1:0] araddr,
    // AXI4-Lite read data channel
    input  logic                  rvalid,
    output logic                  rready,
    input  line_t                 rdata,
    // line write into the cache
    output logic                  write_en,
    output fetch_addr_u           write_addr,
    output line_t                 write_data
);

    ////////////////////
    // state encoding
    ////////////////////

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    logic [1:0]  state;
    // fill_addr with the byte offset forced to zero
    fetch_addr_u req_line;
    // line being fetched, held until the write
    fetch_addr_u line_addr;

    always_comb begin
        req_line          = fill_addr;
        req_line.f.offset = '0;
    end

    ////////////////////
    // control FSM
    ////////////////////

    // idle  -> ack a request, then move to addr in the ack cycle
    // addr  -> hold arvalid until arready
    // data  -> hold rready until rvalid
    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ST_IDLE;
            fill_ack <= 1'b0;
        end else begin
            // ack is a single cycle pulse
            fill_ack <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fill_ack) begin
                        state <= ST_ADDR;
                    end else if (fill_req) begin
                        fill_ack <= 1'b1;
                    end
                end
                ST_ADDR: begin
                    if (arready) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    // back to idle the cycle after the r handshake
                    if (rvalid) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // capture the line on acceptance
    always_ff @(posedge clock) begin
        if (state == ST_IDLE && fill_ack) begin
            line_addr <= req_line;
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    // mark the line pending as soon as the request is taken
    assign alloc_en   = fill_ack;
    assign alloc_addr = req_line;

    // address stays stable from the ack until the write
    assign arvalid = (state == ST_ADDR);
    assign araddr  = line_addr.raw;
    assign rready  = (state == ST_DATA);

    // one write per fill, in the r handshake cycle
    assign write_en   = rready && rvalid;
    assign write_addr = line_addr;
    assign write_data = rdata;

endmodule

//--- rtl/icache.sv
// direct mapped, read window is combinational from pc
// alloc bits are not tag checked, a stale alloc only delays a request

`timescale 1ns/1ps
`include "fetch_params.svh"

module icache
    import fetch_pkg::*;
(
    input  logic                             clock,
    input  logic                             reset,
    // fetch address, window starts at its line
    input  fetch_addr_u                      pc,
    // pending mark from the fill path
    input  logic                             alloc_en,
    input  fetch_addr_u                      alloc_addr,
    // returned line from the fill path
    input  logic                             write_en,
    input  fetch_addr_u                      write_addr,
    input  line_t                            write_data,
    // window, slot 0 is the pc line
    output line_t [`PREFETCH_DISTANCE-1:0]   line_data,
    output logic  [`PREFETCH_DISTANCE-1:0]   line_valid,
    output logic  [`PREFETCH_DISTANCE-1:0]   line_alloc
);

    ////////////////////
    // storage
    ////////////////////

    line_t                  data_mem [`ICACHE_LINES];
    logic [`TAG_BITS-1:0]   tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_bits;
    // fill requested but line not yet back
    logic [`ICACHE_LINES-1:0] alloc_bits;

    // per slot lookup, one extra bit to catch the index wrap
    logic [`ICACHE_LINE_BITS:0]   slot_sum   [`PREFETCH_DISTANCE];
    logic [`ICACHE_LINE_BITS-1:0] slot_index [`PREFETCH_DISTANCE];
    logic [`TAG_BITS-1:0]         slot_tag   [`PREFETCH_DISTANCE];

    ////////////////////
    // read window
    ////////////////////

    always_comb begin
        for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
            slot_sum[i] = {1'b0, pc.f.index} + (`ICACHE_LINE_BITS + 1)'(i);
            // low bits give the index modulo the line count
            slot_index[i] = slot_sum[i][`ICACHE_LINE_BITS-1:0];
            // wrap past the last line moves into the next tag
            slot_tag[i] = pc.f.tag
                + {{(`TAG_BITS - 1){1'b0}}, slot_sum[i][`ICACHE_LINE_BITS]};

            line_data[i]  = data_mem[slot_index[i]];
            line_valid[i] = valid_bits[slot_index[i]]
                && (tag_mem[slot_index[i]] == slot_tag[i]);
            line_alloc[i] = alloc_bits[slot_index[i]];
        end
    end

    ////////////////////
    // valid and alloc
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
            alloc_bits <= '0;
        end else begin
            // returned line is valid, no longer pending
            if (write_en) begin
                valid_bits[write_addr.f.index] <= 1'b1;
                alloc_bits[write_addr.f.index] <= 1'b0;
            end
            // later assignment, so alloc wins on the same line
            if (alloc_en) begin
                alloc_bits[alloc_addr.f.index] <= 1'b1;
            end
        end
    end

    ////////////////////
    // tag and data
    ////////////////////

    always_ff @(posedge clock) begin
        if (write_en) begin
            tag_mem[write_addr.f.index]  <= write_addr.f.tag;
            data_mem[write_addr.f.index] <= write_data;
        end
    end

endmodule

//--- rtl/fetch_window.sv
// pc is word aligned, the low two bits of redirect_pc are ignored
// pending fills are not squashed on redirect

`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_window
    import fetch_pkg::*;
(
    input  logic                             clock,
    input  logic                             reset,
    // window from the cache
    input  line_t [`PREFETCH_DISTANCE-1:0]   line_data,
    input  logic  [`PREFETCH_DISTANCE-1:0]   line_valid,
    input  logic  [`PREFETCH_DISTANCE-1:0]   line_alloc,
    output fetch_addr_u                      pc,
    // instruction stream to the next stage
    output logic                             inst_valid,
    input  logic                             inst_ready,
    output logic [31:0]                      inst,
    output fetch_addr_u                      inst_pc,
    // redirect, always taken
    input  logic                             redirect_valid,
    input  fetch_addr_u                      redirect_pc,
    // fill request to the fill master
    output logic                             fill_req,
    output fetch_addr_u                      fill_addr,
    input  logic                             fill_ack
);

    // start of the pc line
    fetch_addr_u                   line_base;
    // slots that are neither present nor pending
    logic [`PREFETCH_DISTANCE-1:0] slot_miss;

    ////////////////////
    // program counter
    ////////////////////

    // redirect has priority over an advance
    always_ff @(posedge clock) begin
        if (reset) begin
            pc.raw <= `RESET_PC;
        end else if (redirect_valid) begin
            pc.raw <= {redirect_pc.raw[`ADDR_BITS-1:2], 2'b00};
        end else if (inst_valid && inst_ready) begin
            pc.raw <= pc.raw + (`ADDR_BITS)'(4);
        end
    end

    ////////////////////
    // instruction out
    ////////////////////

    // present only when the pc line hits
    assign inst_valid = line_valid[0];
    // offset bit 2 picks the upper word of the line
    assign inst    = line_data[0][pc.f.offset[2]];
    assign inst_pc = pc;

    ////////////////////
    // miss request
    ////////////////////

    always_comb begin
        line_base          = pc;
        line_base.f.offset = '0;
    end

    assign slot_miss = ~line_valid & ~line_alloc;

    // first missing slot wins, so the pc line goes before the prefetch
    always_comb begin
        fill_addr = line_base;
        for (int i = `PREFETCH_DISTANCE - 1; i >= 0; i--) begin
            if (slot_miss[i]) begin
                fill_addr.raw = line_base.raw
                    + (`ADDR_BITS)'(i << `OFFSET_BITS);
            end
        end
    end

    // alloc shows up the cycle after the ack, drop the request meanwhile
    assign fill_req = (|slot_miss) && !fill_ack;

endmodule

//--- rtl/ifetch_top.sv
// instruction fetch top, AXI4-Lite read channels only
// one instruction per cycle on a hit, miss latency depends on memory

`timescale 1ns/1ps
`include "fetch_params.svh"

module ifetch_top
    import fetch_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    // instruction stream
    output logic                  inst_valid,
    input  logic                  inst_ready,
    output logic [31:0]           inst,
    output fetch_addr_u           inst_pc,
    // redirect
    input  logic                  redirect_valid,
    input  fetch_addr_u           redirect_pc,
    // AXI4-Lite read
    output logic                  arvalid,
    input  logic                  arready,
    output logic [`ADDR_BITS-1:0] araddr,
    input  logic                  rvalid,
    output logic                  rready,
    input  line_t                 rdata
);

    ////////////////////
    // internal wires
    ////////////////////

    fetch_addr_u                    pc;
    line_t [`PREFETCH_DISTANCE-1:0] line_data;
    logic  [`PREFETCH_DISTANCE-1:0] line_valid;
    logic  [`PREFETCH_DISTANCE-1:0] line_alloc;
    // window to fill master
    logic                           fill_req;
    fetch_addr_u                    fill_addr;
    logic                           fill_ack;
    // fill master to cache
    logic                           alloc_en;
    fetch_addr_u                    alloc_addr;
    logic                           write_en;
    fetch_addr_u                    write_addr;
    line_t                          write_data;

    // producer, memory to cache
    line_fill_master u_fill (
        .clock      (clock),
        .reset      (reset),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr),
        .fill_ack   (fill_ack),
        .alloc_en   (alloc_en),
        .alloc_addr (alloc_addr),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data)
    );

    // buffer
    icache u_icache (
        .clock      (clock),
        .reset      (reset),
        .pc         (pc),
        .alloc_en   (alloc_en),
        .alloc_addr (alloc_addr),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .line_data  (line_data),
        .line_valid (line_valid),
        .line_alloc (line_alloc)
    );

    // consumer
    fetch_window u_window (
        .clock          (clock),
        .reset          (reset),
        .line_data      (line_data),
        .line_valid     (line_valid),
        .line_alloc     (line_alloc),
        .pc             (pc),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fill_req       (fill_req),
        .fill_addr      (fill_addr),
        .fill_ack       (fill_ack)
    );

endmodule

//--- verification/tb_clock_gen.sv
// testbench clock, 4 ns period, reset high over the first 5 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // released 1 ns after the fifth rising edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

//--- verification/axi_rom_model.sv
// AXI4-Lite read slave, each word is a fixed function of its byte address
// one read at a time, outputs change 1 ns after the rising edge

`timescale 1ns/1ps
`include "fetch_params.svh"

module axi_rom_model
    import fetch_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    // read address channel
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [`ADDR_BITS-1:0] araddr,
    // read data channel
    output logic                  rvalid,
    input  logic                  rready,
    output line_t                 rdata
);

    logic [`ADDR_BITS-1:0] read_addr;
    int                    delay;

    // rom contents, mixes all address bits into the word
    function automatic logic [31:0] word_at(input logic [`ADDR_BITS-1:0] addr);
        return {addr ^ 16'hc3a5, addr} ^ (32'(addr) * 32'h9e3779b1);
    endfunction

    ////////////////////
    // read responder
    ////////////////////

    // master outputs are registered, so they are settled at +1 ns
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        forever begin
            @(posedge clock);
            #1;
            if (arvalid && !reset) begin
                // random address stall, arvalid has to hold meanwhile
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge clock);
                    #1;
                end
                arready   = 1'b1;
                read_addr = araddr;
                @(posedge clock);
                #1;
                arready = 1'b0;
                // random data latency
                delay = $urandom % 6;
                repeat (delay) begin
                    @(posedge clock);
                    #1;
                end
                // word 0 of the line at the lower address
                rdata[0] = word_at(read_addr);
                rdata[1] = word_at(read_addr + 16'd4);
                rvalid   = 1'b1;
                while (!rready) begin
                    @(posedge clock);
                    #1;
                end
                @(posedge clock);
                #1;
                rvalid = 1'b0;
            end
        end
    end

endmodule

//--- verification/ifetch_tb.sv
// assertions sample on the falling edge, stimulus moves 1 ns after the rising edge
// expected words use the same address mixing as the rom model

`timescale 1ns/1ps
`include "fetch_params.svh"

module ifetch_tb
    import fetch_pkg::*;
();

    // instructions taken over all phases and the basis of the watchdog
    localparam int INST_TOTAL = 124;

    logic                  clock;
    logic                  reset;
    logic                  inst_valid;
    logic                  inst_ready;
    logic [31:0]           inst;
    fetch_addr_u           inst_pc;
    logic                  redirect_valid;
    fetch_addr_u           redirect_pc;
    logic                  arvalid;
    logic                  arready;
    logic [`ADDR_BITS-1:0] araddr;
    logic                  rvalid;
    logic                  rready;
    line_t                 rdata;
    logic                  accept;

    // reference state updated on the rising edge
    logic [`ADDR_BITS-1:0] exp_pc;
    logic                  hold_prev;
    logic [31:0]           prev_inst;
    logic [`ADDR_BITS-1:0] prev_inst_pc;
    logic                  ar_wait_prev;
    logic [`ADDR_BITS-1:0] prev_araddr;
    // between address and data handshake
    logic                  ar_pending;
    logic                  fill_seen;
    // current line was entered at its first word
    logic                  base_entry;
    // pc just walked into a new line after a whole line
    logic                  seq_enter;
    // every line address that appeared on araddr
    bit [8191:0]           line_seen;

    tb_clock_gen u_clock (
        .clock (clock),
        .reset (reset)
    );

    ifetch_top u_dut (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata)
    );

    axi_rom_model u_rom (
        .clock   (clock),
        .reset   (reset),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata)
    );

    assign accept = inst_valid && inst_ready;

    function automatic logic [31:0] expected_word(input logic [`ADDR_BITS-1:0] addr);
        return {addr ^ 16'hc3a5, addr} ^ (32'(addr) * 32'h9e3779b1);
    endfunction

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // waits for count transfers while inst_ready toggles at random
    task automatic take_instructions(input int count);
        int taken;
        taken = 0;
        while (taken < count) begin
            @(negedge clock);
            if (accept) begin
                taken++;
            end
            @(posedge clock);
            #1;
            inst_ready = ($urandom % 4) != 0;
        end
    endtask

    task automatic jump_to(input logic [`ADDR_BITS-1:0] target);
        redirect_valid  = 1'b1;
        redirect_pc.raw = target;
        @(posedge clock);
        #1;
        redirect_valid = 1'b0;
    endtask

    ////////////////////
    // reference model
    ////////////////////

    always @(posedge clock) begin
        if (reset) begin
            exp_pc       <= `RESET_PC;
            hold_prev    <= 1'b0;
            ar_wait_prev <= 1'b0;
            ar_pending   <= 1'b0;
            fill_seen    <= 1'b0;
            base_entry   <= 1'b1;
            seq_enter    <= 1'b0;
        end else begin
            hold_prev    <= inst_valid && !inst_ready && !redirect_valid;
            prev_inst    <= inst;
            prev_inst_pc <= inst_pc.raw;
            ar_wait_prev <= arvalid && !arready;
            prev_araddr  <= araddr;
            if (arvalid) begin
                fill_seen                <= 1'b1;
                line_seen[araddr[15:3]]  <= 1'b1;
            end
            if (arvalid && arready) begin
                ar_pending <= 1'b1;
            end else if (rvalid && rready) begin
                ar_pending <= 1'b0;
            end
            seq_enter <= 1'b0;
            // redirect wins over the transfer in the same cycle
            if (redirect_valid) begin
                exp_pc     <= {redirect_pc.raw[`ADDR_BITS-1:2], 2'b00};
                base_entry <= !redirect_pc.raw[2];
            end else if (accept) begin
                exp_pc <= exp_pc + 16'd4;
                if (inst_pc.raw[2]) begin
                    seq_enter  <= base_entry;
                    base_entry <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // assertions
    ////////////////////

    startup_quiet: assert property (@(negedge clock) disable iff (reset)
        !fill_seen |-> !inst_valid && !rready)
        else begin
            $display("inst_valid or rready rose before the first read address");
            stop_with_failure();
        end

    pc_order: assert property (@(negedge clock) disable iff (reset)
        accept |-> inst_pc.raw == exp_pc)
        else begin
            $display("ERR %0t inst_pc expected=%h actual=%h", $time, exp_pc, inst_pc.raw);
            stop_with_failure();
        end

    inst_data: assert property (@(negedge clock) disable iff (reset)
        accept |-> inst == expected_word(inst_pc.raw))
        else begin
            $display("ERR %0t inst expected=%h actual=%h", $time,
                expected_word(inst_pc.raw), inst);
            stop_with_failure();
        end

    // a line overwritten under a held pc may drop inst_valid
    hold_pc: assert property (@(negedge clock) disable iff (reset)
        hold_prev |-> inst_pc.raw == prev_inst_pc)
        else begin
            $display("ERR %0t inst_pc expected=%h actual=%h", $time, prev_inst_pc, inst_pc.raw);
            stop_with_failure();
        end

    hold_inst: assert property (@(negedge clock) disable iff (reset)
        hold_prev && inst_valid |-> inst == prev_inst)
        else begin
            $display("ERR %0t inst expected=%h actual=%h", $time, prev_inst, inst);
            stop_with_failure();
        end

    ar_aligned: assert property (@(negedge clock) disable iff (reset)
        arvalid |-> araddr[2:0] == 3'b000)
        else begin
            $display("ERR %0t araddr expected=%h actual=%h", $time,
                {araddr[15:3], 3'b000}, araddr);
            stop_with_failure();
        end

    ar_hold: assert property (@(negedge clock) disable iff (reset)
        ar_wait_prev |-> arvalid && araddr == prev_araddr)
        else begin
            $display("ERR %0t araddr expected=%h actual=%h", $time, prev_araddr, araddr);
            stop_with_failure();
        end

    one_read: assert property (@(negedge clock) disable iff (reset)
        ar_pending |-> !arvalid)
        else begin
            $display("new read address issued before the previous data returned");
            stop_with_failure();
        end

    // next line read must be out no later than pc reaching it
    prefetch: assert property (@(negedge clock) disable iff (reset)
        seq_enter |-> line_seen[inst_pc.raw[15:3]]
            || (arvalid && araddr == {inst_pc.raw[15:3], 3'b000}))
        else begin
            $display("line at %h was not prefetched before pc entered it", inst_pc.raw);
            stop_with_failure();
        end

    ////////////////////
    // watchdog
    ////////////////////

    initial begin
        #(INST_TOTAL * 64 * 4);
        $display("watchdog expired before all instructions were taken");
        stop_with_failure();
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        void'($urandom(32'h5b795a77));
        inst_ready      = 1'b0;
        redirect_valid  = 1'b0;
        redirect_pc.raw = '0;
        wait (!reset);
        @(posedge clock);
        #1;
        // linear run from reset that wraps the index once
        take_instructions(40);
        // index 0 again with a new tag and entered at the second word
        jump_to(16'h0404);
        take_instructions(12);
        // low bits are dropped and line 0x10 was replaced meanwhile
        jump_to(16'h0012);
        take_instructions(10);
        jump_to(16'h1238);
        take_instructions(8);
        jump_to(16'h0800);
        take_instructions(6);
        // linear run across the index wrap into the next tag
        jump_to(16'h0f70);
        take_instructions(48);
        repeat (4) @(posedge clock);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- all.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/line_fill_master.sv
rtl/icache.sv
rtl/fetch_window.sv
rtl/ifetch_top.sv
verification/tb_clock_gen.sv
verification/axi_rom_model.sv
verification/ifetch_tb.sv

//--- Makefile
# Verilator flow for the instruction fetch subsystem
# sim passes only if the log holds the pass line

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module ifetch_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f all.f --top-module ifetch_tb -Mdir obj_dir -o ifetch_sim
	./obj_dir/ifetch_sim | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
